// File: src/cmd_frame_pkg.sv
`default_nettype none

package cmd_frame_pkg;

    // first payload byte of every command frame
    localparam logic [7:0] CMD_MAGIC = 8'h5A;

    // magic, opcode, start address, register count
    localparam int CMD_HDR_BYTES = 4;

    localparam int FIFO_DEPTH = 32;
    localparam int FRAME_LEN_W = 6;

    // opcode carried in payload byte 1
    typedef enum logic [7:0] {
        OP_WRITE = 8'h01,
        OP_CLEAR = 8'h02
    } cmd_op_e;

    // one payload byte from the udp receiver
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;
    } udp_byte_t;

endpackage

`default_nettype wire

// File: src/reg_bank_pkg.sv
`default_nettype none

package reg_bank_pkg;

    localparam int REG_COUNT = 16;
    localparam int REG_ADDR_W = 4;

    // led page layout, four registers per 32-bit word
    localparam int REGS_PER_PAGE = 4;
    localparam int PAGE_COUNT = 4;

    localparam int KEY_STABLE_CYCLES = 16;

    // one access on the shared bank port
    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } bank_req_t;

endpackage

`default_nettype wire

// File: src/udp_rx_capture.sv
`timescale 1ns/100ps
`default_nettype none

module udp_rx_capture (
    input  wire                                  sys_clk,
    input  wire                                  rst,
    input  wire                                  capture_en,
    input  wire cmd_frame_pkg::udp_byte_t        udp_rx,
    input  wire                                  fifo_full,
    output logic                                 wr_en,
    output logic [7:0]                           wdata,
    output logic                                 capture_done,
    output logic [cmd_frame_pkg::FRAME_LEN_W-1:0] frame_len
);
    logic in_dgram;
    logic capturing;
    logic start;
    logic take;

    // a frame only starts on the first byte of a datagram
    assign start = capture_en & udp_rx.valid & ~in_dgram;
    assign take = udp_rx.valid & (capturing | start);

    // bytes offered while the fifo is full are lost
    assign wr_en = take & ~fifo_full;
    assign wdata = udp_rx.data;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            in_dgram <= 1'b0;
            capturing <= 1'b0;
            capture_done <= 1'b0;
            frame_len <= '0;
        end else begin
            capture_done <= take & udp_rx.last;
            if (udp_rx.valid) begin
                in_dgram <= ~udp_rx.last;
            end
            if (take) begin
                capturing <= ~udp_rx.last;
            end
            // length keeps counting past a full fifo, saturating at the top
            if (start) begin
                frame_len <= 1;
            end else if (take && frame_len != '1) begin
                frame_len <= frame_len + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/cmd_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_fifo (
    input  wire        sys_clk,
    input  wire        rst,
    input  wire        wr_en,
    input  wire [7:0]  wdata,
    input  wire        rd_en,
    output logic [7:0] rdata,
    output logic       empty,
    output logic       full
);
    import cmd_frame_pkg::*;

    logic [7:0] mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH):0] count;
    logic do_wr;
    logic do_rd;

    assign empty = (count == '0);
    assign full = (count == FIFO_DEPTH);
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_wr - do_rd;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
        if (do_rd) begin
            rdata <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: src/cmd_parser.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_parser (
    input  wire                                  sys_clk,
    input  wire                                  rst,
    input  wire                                  parse_en,
    input  wire [cmd_frame_pkg::FRAME_LEN_W-1:0] frame_len,
    input  wire                                  fifo_empty,
    output logic                                 rd_en,
    input  wire [7:0]                            rdata,
    output reg_bank_pkg::bank_req_t              bank_req,
    output logic                                 parse_done,
    output logic                                 frame_ok,
    output logic                                 frame_err
);
    import cmd_frame_pkg::*;
    import reg_bank_pkg::*;

    typedef enum logic [2:0] {
        P_IDLE,
        P_HDR,
        P_CHECK,
        P_WRITE,
        P_CLEAR,
        P_DRAIN,
        P_DONE
    } state_e;

    state_e state;
    logic [7:0] hdr [CMD_HDR_BYTES];
    logic [7:0] hdr_want;
    logic [7:0] issued;
    logic [7:0] landed;
    logic [REG_ADDR_W-1:0] addr_q;
    logic rd_pend;
    logic ok_q;
    logic [8:0] span;
    logic frame_good;

    // a clear frame stops after the opcode
    assign hdr_want = (frame_len < CMD_HDR_BYTES) ? 8'(frame_len) : 8'(CMD_HDR_BYTES);
    assign span = 9'(hdr[2]) + 9'(hdr[3]);

    always_comb begin
        frame_good = 1'b0;
        if (hdr[0] == CMD_MAGIC) begin
            if (hdr[1] == OP_WRITE) begin
                frame_good = (frame_len >= CMD_HDR_BYTES)
                    && (span <= 9'(REG_COUNT))
                    && (9'(frame_len) == 9'(CMD_HDR_BYTES) + 9'(hdr[3]));
            end else if (hdr[1] == OP_CLEAR) begin
                frame_good = (frame_len == FRAME_LEN_W'(2));
            end
        end
    end

    always_comb begin
        case (state)
            P_HDR: rd_en = ~fifo_empty & (issued < hdr_want);
            P_WRITE: rd_en = ~fifo_empty & (issued < hdr[3]);
            P_DRAIN: rd_en = ~fifo_empty;
            default: rd_en = 1'b0;
        endcase
    end

    // data bytes go straight to the bank as they leave the fifo
    always_comb begin
        bank_req = '0;
        if (state == P_WRITE && rd_pend) begin
            bank_req.req = 1'b1;
            bank_req.we = 1'b1;
            bank_req.addr = addr_q;
            bank_req.wdata = rdata;
        end else if (state == P_CLEAR) begin
            bank_req.req = 1'b1;
            bank_req.we = 1'b1;
            bank_req.addr = addr_q;
        end
    end

    assign parse_done = (state == P_DONE);
    assign frame_ok = parse_done & ok_q;
    assign frame_err = parse_done & ~ok_q;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            state <= P_IDLE;
            issued <= '0;
            landed <= '0;
            addr_q <= '0;
            rd_pend <= 1'b0;
            ok_q <= 1'b0;
        end else begin
            rd_pend <= rd_en;
            if (rd_en) begin
                issued <= issued + 8'd1;
            end
            if (rd_pend) begin
                landed <= landed + 8'd1;
            end
            case (state)
                P_IDLE: begin
                    if (parse_en) begin
                        state <= P_HDR;
                        issued <= '0;
                        landed <= '0;
                    end
                end
                P_HDR: begin
                    if (landed == hdr_want && !rd_pend) begin
                        state <= P_CHECK;
                    end
                end
                P_CHECK: begin
                    ok_q <= frame_good;
                    issued <= '0;
                    landed <= '0;
                    addr_q <= hdr[2][REG_ADDR_W-1:0];
                    if (!frame_good) begin
                        state <= P_DRAIN;
                    end else if (hdr[1] == OP_CLEAR) begin
                        state <= P_CLEAR;
                        addr_q <= '0;
                    end else begin
                        state <= P_WRITE;
                    end
                end
                P_WRITE: begin
                    if (rd_pend) begin
                        addr_q <= addr_q + 1'b1;
                    end
                    if (landed == hdr[3] && !rd_pend) begin
                        state <= P_DRAIN;
                    end
                end
                P_CLEAR: begin
                    addr_q <= addr_q + 1'b1;
                    if (addr_q == REG_ADDR_W'(REG_COUNT - 1)) begin
                        state <= P_DRAIN;
                    end
                end
                P_DRAIN: begin
                    if (fifo_empty && !rd_pend) begin
                        state <= P_DONE;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // header bytes land one cycle after their read
    always_ff @(posedge sys_clk) begin
        if (state == P_HDR && rd_pend) begin
            hdr[landed[$clog2(CMD_HDR_BYTES)-1:0]] <= rdata;
        end
    end

endmodule

`default_nettype wire

// File: src/reg_bank.sv
`timescale 1ns/100ps
`default_nettype none

module reg_bank (
    input  wire                            sys_clk,
    input  wire                            rst,
    input  wire reg_bank_pkg::bank_req_t   parser_req,
    input  wire reg_bank_pkg::bank_req_t   scan_req,
    output logic                           scan_grant,
    output logic [7:0]                     rdata
);
    import reg_bank_pkg::*;

    logic [7:0] regs [REG_COUNT];
    bank_req_t sel;

    // parser has fixed priority on the single port
    assign scan_grant = scan_req.req & ~parser_req.req;
    assign sel = parser_req.req ? parser_req : scan_req;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (sel.req && sel.we) begin
            regs[sel.addr] <= sel.wdata;
        end
    end

    // read data follows the grant by one cycle
    always_ff @(posedge sys_clk) begin
        if (sel.req && !sel.we) begin
            rdata <= regs[sel.addr];
        end
    end

endmodule

`default_nettype wire

// File: src/key_debounce.sv
`timescale 1ns/100ps
`default_nettype none

module key_debounce (
    input  wire  sys_clk,
    input  wire  rst,
    input  wire  key,
    output logic press
);
    import reg_bank_pkg::*;

    logic [1:0] sync;
    logic level;
    logic [$clog2(KEY_STABLE_CYCLES)-1:0] cnt;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            sync <= '0;
            level <= 1'b0;
            cnt <= '0;
            press <= 1'b0;
        end else begin
            sync <= {sync[0], key};
            press <= 1'b0;
            if (sync[1] == level) begin
                cnt <= '0;
            end else if (cnt == $bits(cnt)'(KEY_STABLE_CYCLES - 1)) begin
                // new level held long enough
                level <= sync[1];
                cnt <= '0;
                press <= sync[1];
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/led_scanner.sv
`timescale 1ns/100ps
`default_nettype none

module led_scanner (
    input  wire                        sys_clk,
    input  wire                        rst,
    input  wire                        page_up,
    input  wire                        page_down,
    output reg_bank_pkg::bank_req_t    scan_req,
    input  wire                        scan_grant,
    input  wire [7:0]                  rdata,
    output logic [31:0]                led
);
    import reg_bank_pkg::*;

    logic [$clog2(PAGE_COUNT)-1:0] page;
    logic [$clog2(PAGE_COUNT)-1:0] req_page;
    logic [$clog2(REGS_PER_PAGE)-1:0] lane;
    logic [$clog2(REGS_PER_PAGE)-1:0] rd_lane;
    logic req_on;
    logic restart;
    logic rd_pend;

    // request only moves on after its grant
    always_comb begin
        scan_req.req = req_on;
        scan_req.we = 1'b0;
        scan_req.addr = REG_ADDR_W'(req_page * REGS_PER_PAGE + lane);
        scan_req.wdata = '0;
    end

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            page <= '0;
            req_page <= '0;
            lane <= '0;
            rd_lane <= '0;
            req_on <= 1'b0;
            restart <= 1'b0;
            rd_pend <= 1'b0;
            led <= '0;
        end else begin
            req_on <= 1'b1;
            rd_pend <= scan_grant;
            if (scan_grant) begin
                rd_lane <= lane;
                req_page <= page;
                restart <= 1'b0;
                if (restart || lane == REGS_PER_PAGE - 1) begin
                    lane <= '0;
                end else begin
                    lane <= lane + 1'b1;
                end
            end
            // a page change restarts the sweep at lane 0
            if (page_up && !page_down) begin
                page <= (page == PAGE_COUNT - 1) ? '0 : page + 1'b1;
                restart <= 1'b1;
            end else if (page_down && !page_up) begin
                page <= (page == 0) ? $bits(page)'(PAGE_COUNT - 1) : page - 1'b1;
                restart <= 1'b1;
            end
            if (rd_pend) begin
                led[rd_lane*8 +: 8] <= rdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rx_console.sv
`timescale 1ns/100ps
`default_nettype none

module rx_console (
    input  wire                            sys_clk,
    input  wire                            rst,
    input  wire cmd_frame_pkg::udp_byte_t  udp_rx,
    input  wire                            capture_done,
    input  wire                            parse_done,
    output logic                           capture_en,
    output logic                           parse_en,
    output logic                           frame_drop,
    output logic                           busy
);
    typedef enum logic [1:0] {
        IDLE,
        LISTEN,
        CAPTURE,
        PARSE
    } state_e;

    state_e state;
    logic in_dgram;
    logic drop_active;
    logic first_byte;
    logic drop_start;

    assign first_byte = udp_rx.valid & ~in_dgram;
    assign drop_start = first_byte & (state != LISTEN);

    // one drop report per ignored datagram, on its last byte
    assign frame_drop = udp_rx.valid & udp_rx.last & (drop_active | drop_start);

    assign capture_en = (state == LISTEN);
    assign parse_en = (state == PARSE);
    assign busy = (state != LISTEN);

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            in_dgram <= 1'b0;
            drop_active <= 1'b0;
        end else begin
            if (udp_rx.valid) begin
                in_dgram <= ~udp_rx.last;
            end
            if (drop_start && !udp_rx.last) begin
                drop_active <= 1'b1;
            end else if (udp_rx.valid && udp_rx.last) begin
                drop_active <= 1'b0;
            end
            case (state)
                IDLE: state <= LISTEN;
                LISTEN: begin
                    if (first_byte) begin
                        state <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (capture_done) begin
                        state <= PARSE;
                    end
                end
                PARSE: begin
                    if (parse_done) begin
                        state <= LISTEN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/cmd_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_rx_top (
    input  wire                            sys_clk,
    input  wire                            rst,
    input  wire cmd_frame_pkg::udp_byte_t  udp_rx,
    input  wire                            key_up,
    input  wire                            key_down,
    output logic [31:0]                    led,
    output logic                           frame_ok,
    output logic                           frame_err,
    output logic                           frame_drop,
    output logic                           busy
);
    import cmd_frame_pkg::*;
    import reg_bank_pkg::*;

    // console strobes
    wire capture_en;
    wire capture_done;
    wire parse_en;
    wire parse_done;

    // command fifo
    wire fifo_wr_en;
    wire [7:0] fifo_wdata;
    wire fifo_rd_en;
    wire [7:0] fifo_rdata;
    wire fifo_empty;
    wire fifo_full;
    wire [FRAME_LEN_W-1:0] frame_len;

    // register bank port
    wire bank_req_t parser_req;
    wire bank_req_t scan_req;
    wire scan_grant;
    wire [7:0] bank_rdata;
    wire page_up;
    wire page_down;

    rx_console u_console (
        .sys_clk(sys_clk),
        .rst(rst),
        .udp_rx(udp_rx),
        .capture_done(capture_done),
        .parse_done(parse_done),
        .capture_en(capture_en),
        .parse_en(parse_en),
        .frame_drop(frame_drop),
        .busy(busy)
    );

    udp_rx_capture u_capture (
        .sys_clk(sys_clk),
        .rst(rst),
        .capture_en(capture_en),
        .udp_rx(udp_rx),
        .fifo_full(fifo_full),
        .wr_en(fifo_wr_en),
        .wdata(fifo_wdata),
        .capture_done(capture_done),
        .frame_len(frame_len)
    );

    cmd_fifo u_fifo (
        .sys_clk(sys_clk),
        .rst(rst),
        .wr_en(fifo_wr_en),
        .wdata(fifo_wdata),
        .rd_en(fifo_rd_en),
        .rdata(fifo_rdata),
        .empty(fifo_empty),
        .full(fifo_full)
    );

    cmd_parser u_parser (
        .sys_clk(sys_clk),
        .rst(rst),
        .parse_en(parse_en),
        .frame_len(frame_len),
        .fifo_empty(fifo_empty),
        .rd_en(fifo_rd_en),
        .rdata(fifo_rdata),
        .bank_req(parser_req),
        .parse_done(parse_done),
        .frame_ok(frame_ok),
        .frame_err(frame_err)
    );

    reg_bank u_bank (
        .sys_clk(sys_clk),
        .rst(rst),
        .parser_req(parser_req),
        .scan_req(scan_req),
        .scan_grant(scan_grant),
        .rdata(bank_rdata)
    );

    key_debounce u_key_up (
        .sys_clk(sys_clk),
        .rst(rst),
        .key(key_up),
        .press(page_up)
    );

    key_debounce u_key_down (
        .sys_clk(sys_clk),
        .rst(rst),
        .key(key_down),
        .press(page_down)
    );

    led_scanner u_scanner (
        .sys_clk(sys_clk),
        .rst(rst),
        .page_up(page_up),
        .page_down(page_down),
        .scan_req(scan_req),
        .scan_grant(scan_grant),
        .rdata(bank_rdata),
        .led(led)
    );

endmodule

`default_nettype wire

// File: testbench/tb_cmd_rx.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cmd_rx;
    import cmd_frame_pkg::*;
    import reg_bank_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    localparam int LISTEN_TIMEOUT = 200;
    localparam int RESULT_TIMEOUT = 500;
    localparam int LED_TIMEOUT = 200;

    logic sys_clk;
    logic rst;
    udp_byte_t udp_rx;
    logic key_up;
    logic key_down;
    logic [31:0] led;
    logic frame_ok;
    logic frame_err;
    logic frame_drop;
    logic busy;

    integer seed;
    int ok_count;
    int err_count;
    int drop_count;

    // reference model of the bank and the shown page
    logic [7:0] exp_regs [REG_COUNT];
    int exp_page;

    cmd_rx_top dut (
        .sys_clk(sys_clk),
        .rst(rst),
        .udp_rx(udp_rx),
        .key_up(key_up),
        .key_down(key_down),
        .led(led),
        .frame_ok(frame_ok),
        .frame_err(frame_err),
        .frame_drop(frame_drop),
        .busy(busy)
    );

    initial begin
        sys_clk = 1'b0;
        forever begin
            #10 sys_clk = ~sys_clk;
        end
    end

    // result pulses counted just before each rising edge
    always @(posedge sys_clk) begin
        if (!rst) begin
            if (frame_ok) ok_count = ok_count + 1;
            if (frame_err) err_count = err_count + 1;
            if (frame_drop) drop_count = drop_count + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout waiting for %s", what);
        $display("Checks failed");
        $fatal(1, "wait limit reached");
    endtask

    // frame rules applied to the model, returns 1 for an accepted frame
    function automatic bit model_apply(input byte_q_t frame);
        int len;
        int addr;
        int count;
        len = frame.size();
        if (len < 2 || frame[0] != CMD_MAGIC) return 1'b0;
        if (frame[1] == OP_CLEAR) begin
            if (len != 2) return 1'b0;
            for (int i = 0; i < REG_COUNT; i++) exp_regs[i] = 8'h00;
            return 1'b1;
        end
        if (frame[1] != OP_WRITE || len < CMD_HDR_BYTES) return 1'b0;
        addr = frame[2];
        count = frame[3];
        if (addr + count > REG_COUNT || len != CMD_HDR_BYTES + count) return 1'b0;
        for (int i = 0; i < count; i++) exp_regs[addr + i] = frame[CMD_HDR_BYTES + i];
        return 1'b1;
    endfunction

    function automatic logic [31:0] page_word(input int page);
        return {exp_regs[page * REGS_PER_PAGE + 3], exp_regs[page * REGS_PER_PAGE + 2],
                exp_regs[page * REGS_PER_PAGE + 1], exp_regs[page * REGS_PER_PAGE]};
    endfunction

    task automatic build_frame(input logic [7:0] magic, input logic [7:0] op,
                               input int addr, input int count, input int n_data,
                               output byte_q_t frame);
        frame = {};
        frame.push_back(magic);
        frame.push_back(op);
        frame.push_back(8'(addr));
        frame.push_back(8'(count));
        for (int i = 0; i < n_data; i++) frame.push_back(8'($random(seed)));
    endtask

    // one byte per valid cycle, random idle gaps in between
    task automatic send_datagram(input byte_q_t frame, input int max_gap);
        int gap;
        for (int i = 0; i < frame.size(); i++) begin
            gap = $unsigned($random(seed)) % (max_gap + 1);
            repeat (gap) begin
                @(negedge sys_clk);
                udp_rx = '0;
            end
            @(negedge sys_clk);
            udp_rx.valid = 1'b1;
            udp_rx.data = frame[i];
            udp_rx.last = (i == frame.size() - 1);
        end
        @(negedge sys_clk);
        udp_rx = '0;
    endtask

    task automatic wait_listen();
        int cycles;
        cycles = 0;
        @(negedge sys_clk);
        while (busy) begin
            if (cycles == LISTEN_TIMEOUT) begin
                report_timeout("console to listen");
            end
            @(negedge sys_clk);
            cycles++;
        end
    endtask

    task automatic wait_result(input string name, input int ok_before, input int err_before,
                               output bit got_ok);
        int cycles;
        cycles = 0;
        while (ok_count == ok_before && err_count == err_before) begin
            if (cycles == RESULT_TIMEOUT) begin
                report_timeout("frame result");
            end
            @(negedge sys_clk);
            cycles++;
        end
        got_ok = (ok_count != ok_before);
        check_value({name, "_pulses"}, 1, (ok_count - ok_before) + (err_count - err_before));
    endtask

    task automatic wait_drop(input int drop_before);
        int cycles;
        cycles = 0;
        while (drop_count == drop_before) begin
            if (cycles == RESULT_TIMEOUT) begin
                report_timeout("frame drop");
            end
            @(negedge sys_clk);
            cycles++;
        end
    endtask

    task automatic run_frame(input string name, input byte_q_t frame);
        int ok_before;
        int err_before;
        bit exp_ok;
        bit got_ok;
        wait_listen();
        ok_before = ok_count;
        err_before = err_count;
        exp_ok = model_apply(frame);
        send_datagram(frame, 3);
        wait_result(name, ok_before, err_before, got_ok);
        check_value({name, "_ok"}, exp_ok, got_ok);
    endtask

    // led refresh has no marker, so poll until it matches
    task automatic check_page(input string name);
        int cycles;
        cycles = 0;
        repeat (12) @(negedge sys_clk);
        while (led !== page_word(exp_page) && cycles < LED_TIMEOUT) begin
            @(negedge sys_clk);
            cycles++;
        end
        check_value($sformatf("%s_page%0d", name, exp_page), page_word(exp_page), led);
    endtask

    task automatic press_key(input bit up);
        @(negedge sys_clk);
        if (up) key_up = 1'b1;
        else key_down = 1'b1;
        repeat (40) @(negedge sys_clk);
        key_up = 1'b0;
        key_down = 1'b0;
        repeat (40) @(negedge sys_clk);
        exp_page = up ? (exp_page + 1) % PAGE_COUNT : (exp_page + PAGE_COUNT - 1) % PAGE_COUNT;
    endtask

    // walks all pages and ends on the page it started from
    task automatic check_all_pages(input string name);
        for (int p = 0; p < PAGE_COUNT; p++) begin
            check_page(name);
            press_key(1'b1);
        end
    endtask

    initial begin
        byte_q_t frame;
        byte_q_t drop_frame;
        int ok_before;
        int err_before;
        int drop_before;
        bit exp_ok;
        bit got_ok;

        rst = 1'b1;
        udp_rx = '0;
        key_up = 1'b0;
        key_down = 1'b0;
        seed = 32'he34e_7a1a;
        ok_count = 0;
        err_count = 0;
        drop_count = 0;
        exp_page = 0;
        for (int i = 0; i < REG_COUNT; i++) exp_regs[i] = 8'h00;
        repeat (16) @(negedge sys_clk);
        rst = 1'b0;

        // reset state, one idle cycle before listen
        check_value("reset_idle_busy", 1, busy);
        @(negedge sys_clk);
        check_value("reset_busy", 0, busy);
        check_value("reset_led", 0, led);
        repeat (20) @(negedge sys_clk);
        check_value("reset_pulses", 0, ok_count + err_count + drop_count);

        // valid writes, partial and full bank
        build_frame(CMD_MAGIC, OP_WRITE, 2, 3, 3, frame);
        run_frame("write_small", frame);
        check_all_pages("write_small");
        build_frame(CMD_MAGIC, OP_WRITE, 0, 16, 16, frame);
        run_frame("write_full", frame);
        check_all_pages("write_full");

        // rejected frames leave the bank alone
        build_frame(8'hA5, OP_WRITE, 0, 2, 2, frame);
        run_frame("bad_magic", frame);
        check_all_pages("bad_magic");
        build_frame(CMD_MAGIC, 8'h07, 0, 2, 2, frame);
        run_frame("bad_opcode", frame);
        check_all_pages("bad_opcode");
        build_frame(CMD_MAGIC, OP_WRITE, 14, 4, 4, frame);
        run_frame("addr_overflow", frame);
        check_all_pages("addr_overflow");
        build_frame(CMD_MAGIC, OP_WRITE, 0, 3, 5, frame);
        run_frame("len_mismatch", frame);
        check_all_pages("len_mismatch");

        // clear
        frame = {CMD_MAGIC, 8'(OP_CLEAR)};
        run_frame("clear", frame);
        check_all_pages("clear");

        // page stepping in both directions
        build_frame(CMD_MAGIC, OP_WRITE, 0, 16, 16, frame);
        run_frame("write_keys", frame);
        press_key(1'b0);
        check_page("key_down_wrap");
        press_key(1'b0);
        check_page("key_down");
        press_key(1'b1);
        check_page("key_up");
        press_key(1'b1);
        check_page("key_up_wrap");
        press_key(1'b1);
        check_page("key_up");
        press_key(1'b0);
        check_page("key_down");

        // datagram arriving while busy is dropped
        wait_listen();
        ok_before = ok_count;
        err_before = err_count;
        drop_before = drop_count;
        build_frame(CMD_MAGIC, OP_WRITE, 0, 16, 16, frame);
        exp_ok = model_apply(frame);
        build_frame(CMD_MAGIC, OP_WRITE, 0, 2, 2, drop_frame);
        send_datagram(frame, 3);
        send_datagram(drop_frame, 0);
        wait_result("long_write", ok_before, err_before, got_ok);
        check_value("long_write_ok", exp_ok, got_ok);
        wait_drop(drop_before);
        wait_listen();
        check_value("drop_count", drop_before + 1, drop_count);
        check_value("drop_no_result", ok_before + 1, ok_count);
        check_value("drop_no_err", err_before, err_count);
        check_all_pages("after_drop");
        build_frame(CMD_MAGIC, OP_WRITE, 5, 2, 2, frame);
        run_frame("after_drop_write", frame);
        check_all_pages("after_drop_write");

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
src/cmd_frame_pkg.sv
src/reg_bank_pkg.sv
src/udp_rx_capture.sv
src/cmd_fifo.sv
src/cmd_parser.sv
src/reg_bank.sv
src/key_debounce.sv
src/led_scanner.sv
src/rx_console.sv
src/cmd_rx_top.sv
testbench/tb_cmd_rx.sv

// File: Bender.yml
package:
  name: cmd_rx

sources:
  - src/cmd_frame_pkg.sv
  - src/reg_bank_pkg.sv
  - src/udp_rx_capture.sv
  - src/cmd_fifo.sv
  - src/cmd_parser.sv
  - src/reg_bank.sv
  - src/key_debounce.sv
  - src/led_scanner.sv
  - src/rx_console.sv
  - src/cmd_rx_top.sv
  - target: test
    files:
      - testbench/tb_cmd_rx.sv
